//--- include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// data path and address widths
////////////////////////////////////////////////////////////////////////////

// register and data width
`define CSR_XLEN 32
// csr address width
`define CSR_ADDR_W 12

// mstatus bit positions, machine mode only
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7
// mpp is two bits wide starting here
`define MSTATUS_MPP_LO 11

// cause is irq flag plus 5-bit code
`define CAUSE_W 6

////////////////////////////////////////////////////////////////////////////
// performance counters
////////////////////////////////////////////////////////////////////////////

`define PERF_N_CNT 8
// bit 0 global enable, bit 1 saturate
`define PCMR_RESET 2'd3

`endif

//--- rtl/csr_pkg.sv
`include "csr_defines.svh"

package csr_pkg;

  // csr operation from the decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // implemented csr addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    MSTATUS  = 12'h300,
    MISA     = 12'h301,
    MTVEC    = 12'h305,
    MEPC     = 12'h341,
    MCAUSE   = 12'h342,
    PCCR0    = 12'h780,
    PCCR1    = 12'h781,
    PCCR2    = 12'h782,
    PCCR3    = 12'h783,
    PCCR4    = 12'h784,
    PCCR5    = 12'h785,
    PCCR6    = 12'h786,
    PCCR7    = 12'h787,
    PCCR_ALL = 12'h79F,
    PCER     = 12'h7A0,
    PCMR     = 12'h7A1,
    MHARTID  = 12'hF14
  } csr_addr_e;

  // request from the core
  typedef struct packed {
    logic                  access;
    logic [`CSR_ADDR_W-1:0] addr;
    csr_op_e               op;
    logic [`CSR_XLEN-1:0]   wdata;
  } csr_req_t;

  // trap strobes from the controller
  typedef struct packed {
    logic                 save_cause;
    logic                 save_if;
    logic                 save_id;
    logic                 restore_mret;
    logic [`CAUSE_W-1:0]  cause;
    logic [`CSR_XLEN-1:0] pc_if;
    logic [`CSR_XLEN-1:0] pc_id;
  } trap_ctrl_t;

  // decoded write strobes, one-hot, plus merged value
  typedef struct packed {
    logic                          mstatus;
    logic                          mepc;
    logic                          mcause;
    logic                          pcer;
    logic                          pcmr;
    logic                          pccr;
    logic                          pccr_all;
    logic [$clog2(`PERF_N_CNT)-1:0] pccr_idx;
    logic [`CSR_XLEN-1:0]           wdata;
  } csr_wr_t;

endpackage

//--- rtl/perf_pkg.sv
`include "csr_defines.svh"

package perf_pkg;

  // counter index, one per event class
  typedef enum logic [$clog2(`PERF_N_CNT)-1:0] {
    CYCLES   = 3'd0,
    INSTR    = 3'd1,
    LD_STALL = 3'd2,
    IMISS    = 3'd3,
    LOAD     = 3'd4,
    STORE    = 3'd5,
    BRANCH   = 3'd6,
    BR_TAKEN = 3'd7
  } perf_evt_e;

  // raw pipeline events
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic ld_stall;
    logic imiss;
    logic pc_set;
    logic mem_load;
    logic mem_store;
    logic branch;
    logic branch_taken;
  } core_evt_t;

endpackage

//--- rtl/csr_access_ctrl.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_access_ctrl import csr_pkg::*; (
  input  csr_req_t                       req_i,
  input  logic [`CSR_XLEN-1:0]            trap_rdata_i,
  input  logic [`PERF_N_CNT-1:0]          pcer_i,
  input  logic [1:0]                     pcmr_i,
  input  logic [`CSR_XLEN-1:0]            pccr_rdata_i,
  output csr_wr_t                        wr_o,
  output logic [$clog2(`PERF_N_CNT)-1:0] pccr_sel_o,
  output logic [`CSR_XLEN-1:0]            csr_rdata_o
);

  logic                 is_mach;
  logic                 is_pcer;
  logic                 is_pcmr;
  logic                 is_pccr;
  logic                 is_pccr_all;
  logic                 we;
  logic [`CSR_XLEN-1:0] rdata_int;
  logic [`CSR_XLEN-1:0] wdata_mrg;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // groups only valid while the core asserts access
  assign is_mach     = req_i.access &&
                       (req_i.addr inside {MSTATUS, MISA, MTVEC, MEPC, MCAUSE, MHARTID});
  assign is_pcer     = req_i.access && (req_i.addr == PCER);
  assign is_pcmr     = req_i.access && (req_i.addr == PCMR);
  // single counters 780..787
  assign is_pccr     = req_i.access && (req_i.addr inside {[PCCR0:PCCR7]});
  assign is_pccr_all = req_i.access && (req_i.addr == PCCR_ALL);

  // low address bits pick the counter
  assign pccr_sel_o  = req_i.addr[$clog2(`PERF_N_CNT)-1:0];

  // read mux, also the old value for set and clear
  // pccr_all and unmapped addresses fall through to zero
  always_comb begin
    rdata_int = '0;
    if (is_mach) begin
      rdata_int = trap_rdata_i;
    end else if (is_pcer) begin
      rdata_int[`PERF_N_CNT-1:0] = pcer_i;
    end else if (is_pcmr) begin
      rdata_int[1:0] = pcmr_i;
    end else if (is_pccr) begin
      rdata_int = pccr_rdata_i;
    end
  end

  assign csr_rdata_o = rdata_int;

  ////////////////////////////////////////////////////////////////////////////
  // write value merge
  ////////////////////////////////////////////////////////////////////////////

  assign we = req_i.access && (req_i.op != CSR_OP_NONE);

  always_comb begin
    unique case (req_i.op)
      CSR_OP_SET:   wdata_mrg = rdata_int | req_i.wdata;
      // same rule for every register incl. counters
      CSR_OP_CLEAR: wdata_mrg = rdata_int & ~req_i.wdata;
      default:      wdata_mrg = req_i.wdata;
    endcase
  end

  // one strobe per access, read-only csrs get none
  assign wr_o.mstatus  = we && (req_i.addr == MSTATUS);
  assign wr_o.mepc     = we && (req_i.addr == MEPC);
  assign wr_o.mcause   = we && (req_i.addr == MCAUSE);
  assign wr_o.pcer     = we && is_pcer;
  assign wr_o.pcmr     = we && is_pcmr;
  assign wr_o.pccr     = we && (is_pccr || is_pccr_all);
  assign wr_o.pccr_all = is_pccr_all;
  assign wr_o.pccr_idx = pccr_sel_o;
  assign wr_o.wdata    = wdata_mrg;

endmodule

//--- rtl/trap_csr_regs.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module trap_csr_regs import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_wr_t                wr_i,
  input  trap_ctrl_t             trap_i,
  input  logic [23:0]            boot_addr_i,
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,
  input  logic [`CSR_ADDR_W-1:0] addr_i,
  output logic [`CSR_XLEN-1:0]   trap_rdata_o,
  output logic [`CSR_XLEN-1:0]   epc_o,
  output logic [23:0]            mtvec_o,
  output logic                   m_irq_enable_o
);

  // mstatus state, mpp is fixed to machine
  logic                 mie_q, mie_n;
  logic                 mpie_q, mpie_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  logic [`CAUSE_W-1:0]  mcause_q, mcause_n;
  logic [`CSR_XLEN-1:0] exception_pc;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  // faulting pc from IF or ID
  assign exception_pc = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;

  // priority: trap entry, then mret, then csr writes
  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    if (trap_i.save_cause) begin
      // stack interrupt enable
      mpie_n   = mie_q;
      mie_n    = 1'b0;
      mepc_n   = exception_pc;
      mcause_n = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      // pop interrupt enable
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end else begin
      if (wr_i.mstatus) begin
        mie_n  = wr_i.wdata[`MSTATUS_MIE_BIT];
        mpie_n = wr_i.wdata[`MSTATUS_MPIE_BIT];
      end
      if (wr_i.mepc) begin
        mepc_n = wr_i.wdata;
      end
      // irq flag from bit 31, code from low bits
      if (wr_i.mcause) begin
        mcause_n = {wr_i.wdata[`CSR_XLEN-1], wr_i.wdata[`CAUSE_W-2:0]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read formatting
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    trap_rdata_o = '0;
    unique case (addr_i)
      MSTATUS: begin
        trap_rdata_o[`MSTATUS_MIE_BIT]      = mie_q;
        trap_rdata_o[`MSTATUS_MPIE_BIT]     = mpie_q;
        // always machine mode
        trap_rdata_o[`MSTATUS_MPP_LO +: 2] = 2'b11;
      end
      // trap base follows the boot address
      MTVEC:   trap_rdata_o = {boot_addr_i, 8'h00};
      MEPC:    trap_rdata_o = mepc_q;
      MCAUSE: begin
        trap_rdata_o[`CSR_XLEN-1]     = mcause_q[`CAUSE_W-1];
        trap_rdata_o[`CAUSE_W-2:0]    = mcause_q[`CAUSE_W-2:0];
      end
      // cluster at 10:5, core at 3:0
      MHARTID: trap_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      // misa reads zero, as does anything else
      default: trap_rdata_o = '0;
    endcase
  end

  assign epc_o          = mepc_q;
  assign mtvec_o        = boot_addr_i;
  assign m_irq_enable_o = mie_q;

endmodule

//--- rtl/perf_event_gen.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_event_gen import perf_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  core_evt_t              evt_i,
  output logic [`PERF_N_CNT-1:0] evt_vec_o
);

  // id stage finished last cycle
  logic id_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= evt_i.id_valid;
    end
  end

  // one condition per counter
  assign evt_vec_o[CYCLES]   = 1'b1;
  assign evt_vec_o[INSTR]    = evt_i.id_valid & evt_i.is_decoding;
  // load use hazards
  assign evt_vec_o[LD_STALL] = evt_i.ld_stall & id_valid_q;
  // fetch wait, jumps and branches excluded
  assign evt_vec_o[IMISS]    = evt_i.imiss & ~evt_i.pc_set;
  assign evt_vec_o[LOAD]     = evt_i.mem_load;
  assign evt_vec_o[STORE]    = evt_i.mem_store;
  assign evt_vec_o[BRANCH]   = evt_i.branch & id_valid_q;
  assign evt_vec_o[BR_TAKEN] = evt_i.branch & evt_i.branch_taken & id_valid_q;

endmodule

//--- rtl/perf_counter_bank.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_counter_bank import csr_pkg::*; import perf_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  csr_wr_t                        wr_i,
  input  logic [`PERF_N_CNT-1:0]          evt_vec_i,
  input  logic [$clog2(`PERF_N_CNT)-1:0] pccr_sel_i,
  output logic [`PERF_N_CNT-1:0]          pcer_o,
  output logic [1:0]                     pcmr_o,
  output logic [`CSR_XLEN-1:0]            pccr_rdata_o
);

  logic [`PERF_N_CNT-1:0]                pcer_q;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]                           pcmr_q;
  logic [`PERF_N_CNT-1:0][`CSR_XLEN-1:0] pccr_q, pccr_n;
  logic [`PERF_N_CNT-1:0]                inc_d, inc_q;
  perf_evt_e                            rd_idx;
  perf_evt_e                            wr_idx;

  assign rd_idx = perf_evt_e'(pccr_sel_i);
  assign wr_idx = perf_evt_e'(wr_i.pccr_idx);

  // enabled events get registered before the add
  assign inc_d = evt_vec_i & pcer_q & {`PERF_N_CNT{pcmr_q[0]}};

  ////////////////////////////////////////////////////////////////////////////
  // counter next value
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `PERF_N_CNT; i++) begin
      pccr_n[i] = pccr_q[i];
      // hold at all-ones when saturating
      if (inc_q[i] && ((pccr_q[i] != '1) || !pcmr_q[1])) begin
        pccr_n[i] = pccr_q[i] + `CSR_XLEN'(1);
      end
      // csr write beats the increment
      if (wr_i.pccr && (wr_i.pccr_all || (wr_idx == perf_evt_e'(i)))) begin
        pccr_n[i] = wr_i.wdata;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `PCMR_RESET;
      inc_q  <= '0;
      pccr_q <= '0;
    end else begin
      if (wr_i.pcer) begin
        pcer_q <= wr_i.wdata[`PERF_N_CNT-1:0];
      end
      if (wr_i.pcmr) begin
        pcmr_q <= wr_i.wdata[1:0];
      end
      inc_q  <= inc_d;
      pccr_q <= pccr_n;
    end
  end

  assign pcer_o       = pcer_q;
  assign pcmr_o       = pcmr_q;
  // selected counter for reads and set/clear merge
  assign pccr_rdata_o = pccr_q[rd_idx];

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_top import csr_pkg::*; import perf_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_req_t             req_i,
  input  trap_ctrl_t           trap_i,
  input  core_evt_t            evt_i,
  input  logic [23:0]          boot_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic [23:0]          mtvec_o,
  output logic                 m_irq_enable_o
);

  csr_wr_t                        wr;
  logic [`CSR_XLEN-1:0]            trap_rdata;
  logic [`PERF_N_CNT-1:0]          pcer;
  logic [1:0]                     pcmr;
  logic [`CSR_XLEN-1:0]            pccr_rdata;
  logic [$clog2(`PERF_N_CNT)-1:0] pccr_sel;
  logic [`PERF_N_CNT-1:0]          evt_vec;

  ////////////////////////////////////////////////////////////////////////////
  // decode, merge and read mux
  ////////////////////////////////////////////////////////////////////////////

  csr_access_ctrl u_access_ctrl (
    .req_i        (req_i),
    .trap_rdata_i (trap_rdata),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_rdata_i (pccr_rdata),
    .wr_o         (wr),
    .pccr_sel_o   (pccr_sel),
    .csr_rdata_o  (csr_rdata_o)
  );

  // machine trap registers
  trap_csr_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_i           (wr),
    .trap_i         (trap_i),
    .boot_addr_i    (boot_addr_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .addr_i         (req_i.addr),
    .trap_rdata_o   (trap_rdata),
    .epc_o          (epc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////////////////////////////////////////

  perf_event_gen u_evt_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .evt_i     (evt_i),
    .evt_vec_o (evt_vec)
  );

  perf_counter_bank u_cnt_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr),
    .evt_vec_i    (evt_vec),
    .pccr_sel_i   (pccr_sel),
    .pcer_o       (pcer),
    .pcmr_o       (pcmr),
    .pccr_rdata_o (pccr_rdata)
  );

endmodule

//--- dv/csr_properties.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_properties import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_req_t             req_i,
  input  trap_ctrl_t           trap_i,
  input  logic [1:0]           pcmr_i,
  input  logic                 m_irq_enable_i,
  input  logic [`CSR_XLEN-1:0] csr_rdata_i
);

  logic mapped;

  // addresses with a read source, pccr_all reads zero too
  assign mapped = (req_i.addr inside {MSTATUS, MISA, MTVEC, MEPC, MCAUSE, MHARTID, PCER, PCMR})
               || (req_i.addr inside {[PCCR0:PCCR7]});

  // counters enabled and saturating right out of reset
  assert property (@(posedge clk) $rose(rst_n) |-> (pcmr_i == `PCMR_RESET))
    else $error("pcmr not at its reset value after reset");

  // trap entry masks interrupts
  assert property (@(posedge clk) disable iff (!rst_n) trap_i.save_cause |=> !m_irq_enable_i)
    else $error("mie still set after trap entry");

  assert property (@(posedge clk) disable iff (!rst_n)
                   !(trap_i.save_cause && trap_i.restore_mret))
    else $error("trap entry and mret strobed together");

  assert property (@(posedge clk) disable iff (!rst_n)
                   (req_i.access && !mapped) |-> (csr_rdata_i == '0))
    else $error("unmapped csr read is not zero");

endmodule

bind csr_top csr_properties u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .req_i          (req_i),
  .trap_i         (trap_i),
  .pcmr_i         (pcmr),
  .m_irq_enable_i (m_irq_enable_o),
  .csr_rdata_i    (csr_rdata_o)
);

//--- dv/tb_csr_top.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_top
  import csr_pkg::*;
  import perf_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RST_CYCLES      = 5;
  localparam int MAX_STEPS       = 64;
  localparam int CYCLES_PER_STEP = 40;
  // step kinds
  localparam int K_CSR    = 0;
  localparam int K_TRAP   = 1;
  localparam int K_MRET   = 2;
  localparam int K_EVENTS = 3;
  localparam int K_IDLE   = 4;
  localparam int K_BAD    = 5;

  logic                 clk;
  logic                 rst_n;
  csr_req_t             req;
  trap_ctrl_t           trap;
  core_evt_t            evt;
  logic [23:0]          boot_addr;
  logic [3:0]           core_id;
  logic [5:0]           cluster_id;
  logic [`CSR_XLEN-1:0] csr_rdata;
  logic [`CSR_XLEN-1:0] epc;
  logic [23:0]          mtvec;
  logic                 irq_en;

  // one entry per pattern line
  int          kind_a  [MAX_STEPS];
  logic [1:0]  op_a    [MAX_STEPS];
  logic [11:0] addr_a  [MAX_STEPS];
  logic [31:0] data_a  [MAX_STEPS];
  int          count_a [MAX_STEPS];
  logic [31:0] exp_a   [MAX_STEPS];
  int          n_steps;
  int          check_cnt;
  int          err_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  int          seed;

  csr_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .trap_i         (trap),
    .evt_i          (evt),
    .boot_addr_i    (boot_addr),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .csr_rdata_o    (csr_rdata),
    .epc_o          (epc),
    .mtvec_o        (mtvec),
    .m_irq_enable_o (irq_en)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // run limit, armed once the pattern count is known
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pattern file
  ////////////////////////////////////////////////////////////////////////////

  function automatic int kind_code(input logic [63:0] s);
    if (s == {40'd0, "csr"}) return K_CSR;
    if (s == {32'd0, "trap"}) return K_TRAP;
    if (s == {32'd0, "mret"}) return K_MRET;
    if (s == {16'd0, "events"}) return K_EVENTS;
    if (s == {32'd0, "idle"}) return K_IDLE;
    return K_BAD;
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      K_CSR:    return "csr";
      K_TRAP:   return "trap";
      K_MRET:   return "mret";
      K_EVENTS: return "events";
      K_IDLE:   return "idle";
      default:  return "unknown";
    endcase
  endfunction

  task automatic load_patterns(output bit opened);
    int               fd;
    int               n;
    logic [8*128-1:0] line_buf;
    logic [63:0]      kind_s;
    logic [31:0]      op_v;
    logic [31:0]      addr_v;
    logic [31:0]      data_v;
    logic [31:0]      cnt_v;
    logic [31:0]      exp_v;
    opened = 1'b0;
    fd = $fopen("dv/csr_patterns.txt", "r");
    if (fd != 0) begin
      opened = 1'b1;
      // comment and blank lines do not yield six fields
      while ($fgets(line_buf, fd) != 0) begin
        n = $sscanf(line_buf, "%s %d %h %h %d %h", kind_s, op_v, addr_v, data_v, cnt_v, exp_v);
        if (n == 6 && n_steps < MAX_STEPS) begin
          kind_a[n_steps]  = kind_code(kind_s);
          op_a[n_steps]    = op_v[1:0];
          addr_a[n_steps]  = addr_v[11:0];
          data_a[n_steps]  = data_v;
          count_a[n_steps] = int'(cnt_v);
          exp_a[n_steps]   = exp_v;
          n_steps++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // step drivers, all start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // read value is the pre-write value, write lands at the next rising edge
  task automatic csr_access(input int idx);
    req.access = 1'b1;
    req.addr   = addr_a[idx];
    req.op     = csr_op_e'(op_a[idx]);
    req.wdata  = data_a[idx];
    #1;
    if (count_a[idx] != 0) begin
      compare_value("csr_rdata_o", csr_rdata, exp_a[idx]);
    end
    @(negedge clk);
    req = '0;
  endtask

  // op 1 takes the pc from IF, op 2 from ID; the other stage gets a decoy
  task automatic trap_entry(input int idx);
    trap.save_cause = 1'b1;
    trap.save_if    = (op_a[idx] == 2'd1);
    trap.save_id    = (op_a[idx] == 2'd2);
    trap.cause      = addr_a[idx][`CAUSE_W-1:0];
    trap.pc_if      = (op_a[idx] == 2'd1) ? data_a[idx] : ~data_a[idx];
    trap.pc_id      = (op_a[idx] == 2'd1) ? ~data_a[idx] : data_a[idx];
    @(negedge clk);
    trap = '0;
    compare_value("epc_o", epc, exp_a[idx]);
    // trap entry always masks interrupts
    compare_value("m_irq_enable_o", 32'(irq_en), 32'd0);
  endtask

  task automatic mret_return(input int idx);
    trap.restore_mret = 1'b1;
    @(negedge clk);
    trap = '0;
    compare_value("epc_o", epc, exp_a[idx]);
    compare_value("m_irq_enable_o", 32'(irq_en), 32'(count_a[idx] & 1));
  endtask

  // one-cycle pulses with 0 to 2 random idle cycles after each
  task automatic drive_events(input int idx);
    int gap;
    for (int p = 0; p < count_a[idx]; p++) begin
      evt = core_evt_t'(data_a[idx][8:0]);
      @(negedge clk);
      evt = '0;
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic run_step(input int idx);
    int errs_before;
    errs_before = err_cnt;
    case (kind_a[idx])
      K_CSR:    csr_access(idx);
      K_TRAP:   trap_entry(idx);
      K_MRET:   mret_return(idx);
      K_EVENTS: drive_events(idx);
      K_IDLE:   repeat (count_a[idx]) @(negedge clk);
      default: begin
        $display("step %0d: unknown step kind in the pattern file", idx);
        err_cnt++;
      end
    endcase
    $display("step %0d %s addr %h: %s", idx, kind_name(kind_a[idx]), addr_a[idx],
             (err_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit opened;
    rst_n       = 1'b0;
    req         = '0;
    trap        = '0;
    evt         = '0;
    boot_addr   = 24'h1C0080;
    core_id     = 4'h5;
    cluster_id  = 6'h2A;
    seed        = 32'h68f8_b421;
    n_steps     = 0;
    check_cnt   = 0;
    err_cnt     = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    load_patterns(opened);
    if (!opened || n_steps == 0) begin
      $display("pattern file dv/csr_patterns.txt missing or empty");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cycle_limit = CYCLES_PER_STEP * n_steps + RST_CYCLES;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      // outputs that need no csr access
      compare_value("mtvec_o", 32'(mtvec), 32'(boot_addr));
      compare_value("epc_o", epc, 32'd0);
      compare_value("m_irq_enable_o", 32'(irq_en), 32'd0);
      $display("reset outputs: %s", (err_cnt == 0) ? "ok" : "FAILED");
      for (int i = 0; i < n_steps; i++) begin
        run_step(i);
      end
      $display("%0d steps, %0d checks, %0d errors", n_steps, check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

//--- dv/csr_patterns.txt
# kind op(0 none,1 write,2 set,3 clear | trap: 1 IF,2 ID) addr(hex | trap: cause)
# data(hex | events: core_evt_t bits) count(csr: check flag | mret: irq | pulses) expected(hex)
csr    0 300 00000000 1 00001800
csr    0 F14 00000000 1 00000545
csr    0 305 00000000 1 1C008000
csr    0 7A1 00000000 1 00000003
csr    1 341 12345678 1 00000000
csr    2 341 0000F00F 1 12345678
csr    3 341 12300070 1 1234F67F
csr    0 341 00000000 1 0004F60F
csr    1 342 FFFFFFFF 1 00000000
csr    3 342 80000003 1 8000001F
csr    0 342 00000000 1 0000001C
csr    1 300 00000008 1 00001800
trap   1 02B 00000A40 0 00000A40
csr    0 342 00000000 1 8000000B
csr    0 300 00000000 1 00001880
mret   0 000 00000000 1 00000A40
csr    0 300 00000000 1 00001888
trap   2 005 00000B00 0 00000B00
csr    1 7A0 00000030 1 00000000
csr    1 79F 00000000 1 00000000
events 0 000 00000008 5 00000000
events 0 000 00000004 3 00000000
idle   0 000 00000000 3 00000000
csr    0 784 00000000 1 00000005
csr    0 785 00000000 1 00000003
csr    0 780 00000000 1 00000000
csr    2 7A0 00000001 1 00000030
csr    1 780 FFFFFFFF 1 00000000
idle   0 000 00000000 4 00000000
csr    0 780 00000000 1 FFFFFFFF
csr    3 7A1 00000002 1 00000003
idle   0 000 00000000 5 00000000
csr    0 780 00000000 1 00000004
csr    3 7A1 00000001 1 00000001
events 0 000 0000000C 4 00000000
idle   0 000 00000000 3 00000000
csr    0 784 00000000 1 00000005
csr    0 785 00000000 1 00000003
csr    0 780 00000000 1 00000007
csr    0 123 00000000 1 00000000

//--- files.f
+incdir+include
rtl/csr_pkg.sv
rtl/perf_pkg.sv
rtl/csr_access_ctrl.sv
rtl/trap_csr_regs.sv
rtl/perf_event_gen.sv
rtl/perf_counter_bank.sv
rtl/csr_top.sv
dv/csr_properties.sv
dv/tb_csr_top.sv

//--- Makefile
TOP := tb_csr_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
